// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int data_w    = 8;    // datapath and pc width
    localparam int rom_depth = 256;  // full 8-bit address space
    localparam int num_regs  = 4;

    localparam string rom_file = "program.hex";  // program image, one byte per line

    typedef logic [data_w-1:0] data_t;  // data word, also pc values
    typedef logic [1:0]        reg_idx_t;

    // upper nibble of every instruction
    // ra in bits 3..2, rb in bits 1..0
    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_mov = 4'h1,  // ra <- rb
        op_add = 4'h2,  // ra <- ra + rb
        op_sub = 4'h3,  // ra <- ra - rb
        op_and = 4'h4,
        op_or  = 4'h5,
        op_inc = 4'h6,  // ra only
        op_dec = 4'h7,  // ra only
        op_ldi = 4'h8,  // ra <- next byte
        op_in  = 4'h9,  // ra <- input port
        op_out = 4'ha,  // output port <- ra
        op_jmp = 4'hb,  // pc <- rb
        op_jz  = 4'hc   // pc <- rb when zero set
    } opcode_t;

endpackage

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu (
    input  cpu_pkg::opcode_t op,
    input  cpu_pkg::data_t   a,       // ra operand, forwarded
    input  cpu_pkg::data_t   b,       // rb operand, forwarded
    output cpu_pkg::data_t   result,
    output logic             zero
);
    import cpu_pkg::*;

    // everything wraps mod 256, no carry out
    always_comb begin
        case (op)
            op_mov: begin
                result = b;
            end
            op_add: begin
                result = a + b;
            end
            op_sub: begin
                result = a - b;
            end
            op_and: begin
                result = a & b;
            end
            op_or: begin
                result = a | b;
            end
            op_inc: begin
                result = a + data_t'(1);  // b ignored
            end
            op_dec: begin
                result = a - data_t'(1);
            end
            default: begin
                result = '0;  // non alu ops, unused upstream
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none

module register_file (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               wr_en,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::data_t    wr_data,
    input  cpu_pkg::reg_idx_t rd_idx_a,
    input  cpu_pkg::reg_idx_t rd_idx_b,
    output cpu_pkg::data_t    rd_data_a,
    output cpu_pkg::data_t    rd_data_b
);
    import cpu_pkg::*;

    data_t regs [num_regs];  // r0..r3

    // single write port from writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_idx_a];  // async read, no bypass here
    assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             stall,           // hold pc and fetch reg
    input  wire             redirect,        // taken jump from execute
    input  cpu_pkg::data_t  redirect_pc,
    output cpu_pkg::data_t  instr,
    output logic            instr_valid,
    output cpu_pkg::data_t  instr_pc_plus1
);
    import cpu_pkg::*;

    data_t pc;                    // address presented to rom
    data_t rom [rom_depth];       // instruction memory
    data_t pc_next_seq;

    initial begin
        $readmemh(rom_file, rom);  // fixed program
    end

    assign pc_next_seq = pc + data_t'(1);

    // program counter, redirect wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_next_seq;
        end
    end

    // fetch register valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else if (redirect) begin
            instr_valid <= 1'b0;  // drop slot after jump
        end else if (!stall) begin
            instr_valid <= 1'b1;
        end
    end

    // fetch register payload
    always_ff @(posedge clk) begin
        if (!redirect && !stall) begin
            instr          <= rom[pc];      // byte at current pc
            instr_pc_plus1 <= pc_next_seq;
        end
    end

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`default_nettype none

module execute_unit (
    input  wire               clk,
    input  wire               rst_n,
    input  cpu_pkg::data_t    instr,        // fetch register
    input  wire               instr_valid,
    input  cpu_pkg::data_t    in_port,
    input  wire               in_valid,
    input  cpu_pkg::data_t    rd_data_a,
    input  cpu_pkg::data_t    rd_data_b,
    input  wire               wb_wr_en,     // writeback stage, for forwarding
    input  cpu_pkg::reg_idx_t wb_wr_idx,
    input  cpu_pkg::data_t    wb_wr_data,
    output cpu_pkg::reg_idx_t rd_idx_a,
    output cpu_pkg::reg_idx_t rd_idx_b,
    output logic              stall,
    output logic              redirect,
    output cpu_pkg::data_t    redirect_pc,
    output logic              in_ack,
    output logic              ex_wr_en,
    output cpu_pkg::reg_idx_t ex_wr_idx,
    output cpu_pkg::data_t    ex_wr_data,
    output logic              ex_out_en
);
    import cpu_pkg::*;

    opcode_t  op;
    reg_idx_t ra;
    reg_idx_t rb;
    data_t    a_val;         // ra after forwarding
    data_t    b_val;         // rb after forwarding
    data_t    alu_result;
    logic     alu_zero;
    logic     zero_q;        // zero flag
    logic     flag_upd;
    logic     imm_pend;      // current slot is ldi data
    reg_idx_t imm_idx;       // ldi destination
    logic     dec_valid;     // real instruction in slot

    assign op        = opcode_t'(instr[7:4]);
    assign ra        = instr[3:2];
    assign rb        = instr[1:0];
    assign dec_valid = instr_valid && !imm_pend;

    assign rd_idx_a = ra;
    assign rd_idx_b = rb;

    // writeback value wins over file on index match
    assign a_val = (wb_wr_en && wb_wr_idx == ra) ? wb_wr_data : rd_data_a;
    assign b_val = (wb_wr_en && wb_wr_idx == rb) ? wb_wr_data : rd_data_b;

    alu alu_inst (
        .op     (op),
        .a      (a_val),
        .b      (b_val),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_comb begin
        ex_wr_en    = 1'b0;
        ex_wr_idx   = ra;
        ex_wr_data  = alu_result;
        ex_out_en   = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = b_val;          // jump target always from rb
        in_ack      = 1'b0;
        flag_upd    = 1'b0;
        if (instr_valid && imm_pend) begin
            ex_wr_en   = 1'b1;        // second ldi slot is the data
            ex_wr_idx  = imm_idx;
            ex_wr_data = instr;
        end else if (instr_valid) begin
            case (op)
                op_mov, op_add, op_sub, op_and, op_or, op_inc, op_dec: begin
                    ex_wr_en = 1'b1;
                    flag_upd = 1'b1;
                end
                op_in: begin
                    if (in_valid) begin
                        ex_wr_en   = 1'b1;
                        ex_wr_data = in_port;
                        in_ack     = 1'b1;  // value consumed this cycle
                    end else begin
                        stall = 1'b1;       // bubbles to writeback
                    end
                end
                op_out: begin
                    ex_out_en  = 1'b1;
                    ex_wr_data = a_val;
                end
                op_jmp: begin
                    redirect = 1'b1;
                end
                op_jz: begin
                    redirect = zero_q;
                end
                default: begin
                end
            endcase
        end
    end

    // only alu group touches the flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero_q <= 1'b0;
        end else if (flag_upd) begin
            zero_q <= alu_zero;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imm_pend <= 1'b0;
        end else if (redirect) begin
            imm_pend <= 1'b0;
        end else if (instr_valid) begin
            imm_pend <= dec_valid && op == op_ldi;  // set by ldi, cleared by its data
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && op == op_ldi) begin
            imm_idx <= ra;
        end
    end

endmodule

`default_nettype wire

// ==== hw/writeback_unit.sv ====
`default_nettype none

module writeback_unit (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               ex_wr_en,
    input  cpu_pkg::reg_idx_t ex_wr_idx,
    input  cpu_pkg::data_t    ex_wr_data,
    input  wire               ex_out_en,
    output logic              wb_wr_en,    // to reg file and forwarding
    output cpu_pkg::reg_idx_t wb_wr_idx,
    output cpu_pkg::data_t    wb_wr_data,
    output cpu_pkg::data_t    out_port,
    output logic              out_valid
);

    // control bits of the last stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_wr_en  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            wb_wr_en  <= ex_wr_en;
            out_valid <= ex_out_en;  // one pulse per out
        end
    end

    always_ff @(posedge clk) begin
        wb_wr_idx  <= ex_wr_idx;
        wb_wr_data <= ex_wr_data;
    end

    // port keeps last value between outs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_port <= '0;
        end else if (ex_out_en) begin
            out_port <= ex_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`default_nettype none

module cpu_top (
    input  wire             clk,
    input  wire             rst_n,
    input  cpu_pkg::data_t  in_port,
    input  wire             in_valid,
    output logic            in_ack,
    output cpu_pkg::data_t  out_port,
    output logic            out_valid
);
    import cpu_pkg::*;

    data_t    instr;         // fetch -> execute
    logic     instr_valid;
    logic     stall;         // execute -> fetch
    logic     redirect;
    data_t    redirect_pc;
    reg_idx_t rd_idx_a;      // execute <-> reg file
    reg_idx_t rd_idx_b;
    data_t    rd_data_a;
    data_t    rd_data_b;
    logic     ex_wr_en;      // execute -> writeback
    reg_idx_t ex_wr_idx;
    data_t    ex_wr_data;
    logic     ex_out_en;
    logic     wb_wr_en;      // writeback -> reg file, execute
    reg_idx_t wb_wr_idx;
    data_t    wb_wr_data;

    fetch_unit fetch_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .instr_pc_plus1 ()             // not needed, jumps go through rb
    );

    register_file regfile_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wb_wr_en),
        .wr_idx    (wb_wr_idx),
        .wr_data   (wb_wr_data),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    execute_unit execute_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .in_port     (in_port),
        .in_valid    (in_valid),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .wb_wr_en    (wb_wr_en),
        .wb_wr_idx   (wb_wr_idx),
        .wb_wr_data  (wb_wr_data),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .in_ack      (in_ack),
        .ex_wr_en    (ex_wr_en),
        .ex_wr_idx   (ex_wr_idx),
        .ex_wr_data  (ex_wr_data),
        .ex_out_en   (ex_out_en)
    );

    writeback_unit writeback_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_wr_en   (ex_wr_en),
        .ex_wr_idx  (ex_wr_idx),
        .ex_wr_data (ex_wr_data),
        .ex_out_en  (ex_out_en),
        .wb_wr_en   (wb_wr_en),
        .wb_wr_idx  (wb_wr_idx),
        .wb_wr_data (wb_wr_data),
        .out_port   (out_port),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// ==== sim/cpu_sva.sv ====
`default_nettype none

module cpu_sva (
    input wire clk,
    input wire rst_n,
    input wire in_valid,
    input wire in_ack,
    input wire out_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // ack only against an offered value
    ack_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) in_ack |-> in_valid
    ) else $error("in_ack high while in_valid low");

    handshake_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown({in_ack, out_valid})
    ) else $error("in_ack or out_valid unknown after reset");

    // both quiet while held in reset
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> (!in_ack && !out_valid)
    ) else $error("in_ack or out_valid high during reset");

endmodule

bind cpu_top cpu_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ack    (in_ack),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== sim/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int         clk_period     = 20;
    localparam int         reset_cycles   = 8;
    localparam int         timeout_cycles = 200;   // per wait loop
    localparam int         settle_cycles  = 12;    // quiet time after reset
    localparam int         quiet_cycles   = 30;    // tail after last row
    localparam int         num_rows       = 10;
    localparam logic [7:0] lfsr_seed      = 8'd6;

    typedef struct packed {
        data_t x;           // value offered on in_port
        data_t first;       // x + 3 mod 256
        logic  has_second;  // y nonzero
        data_t second;      // y & 3
    } row_t;

    row_t stim_table [num_rows] = '{
        '{8'h00, 8'h03, 1'b1, 8'h03},
        '{8'h01, 8'h04, 1'b1, 8'h00},  // and result zero
        '{8'h7c, 8'h7f, 1'b1, 8'h03},
        '{8'hfc, 8'hff, 1'b1, 8'h03},
        '{8'hfd, 8'h00, 1'b0, 8'h00},  // wraps to zero, jz taken
        '{8'hfd, 8'h00, 1'b0, 8'h00},  // back to back taken jz
        '{8'hfe, 8'h01, 1'b1, 8'h01},
        '{8'hff, 8'h02, 1'b1, 8'h02},
        '{8'h80, 8'h83, 1'b1, 8'h03},
        '{8'h42, 8'h45, 1'b1, 8'h01}
    };

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ack;
    logic       out_valid;
    data_t      in_port;
    data_t      out_port;
    logic       seen_ack;        // sampled once per cycle
    logic       seen_out_valid;
    data_t      seen_out_port;
    logic [7:0] lfsr_state;
    int         owed;            // outputs the current row may make
    int         made;            // outputs seen since the last in_ack
    data_t      last_out;

    cpu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_port   (in_port),
        .in_valid  (in_valid),
        .in_ack    (in_ack),
        .out_port  (out_port),
        .out_valid (out_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[7]);  // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected 0x%02h got 0x%02h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic give_up(input string what);
        $display("no %s within %0d cycles at t=%0t", what, timeout_cycles, $time);
        stop_run();
    endtask

    // drive at falling edge, sample once in_ack has settled
    task automatic cycle(input logic valid, input data_t data);
        @(negedge clk);
        in_valid = valid;
        in_port  = data;
        #1;
        seen_ack       = in_ack;
        seen_out_valid = out_valid;     // registered, stable till next rise
        seen_out_port  = out_port;
        if (seen_out_valid) begin
            made++;
        end
        if (seen_ack && !valid) begin
            $display("in_ack went high at t=%0t while in_valid was low", $time);
            stop_run();
        end
    endtask

    task automatic run_row(input row_t row);
        int gap;
        int waited;
        draw_bits(3, gap);                    // 0..7 idle cycles
        for (int i = 0; i < gap; i++) begin
            cycle(1'b0, ~row.x);              // junk on port, not valid
            check_count("out_valid pulses", owed, made);
        end
        waited = 0;
        cycle(1'b1, row.x);
        check_count("out_valid pulses", owed, made);
        while (!seen_ack) begin               // held until the cpu takes it
            waited++;
            if (waited > timeout_cycles) begin
                give_up("in_ack");
            end
            cycle(1'b1, row.x);
            check_count("out_valid pulses", owed, made);
        end
        made   = 0;
        owed   = row.has_second ? 2 : 1;
        waited = 0;
        while (made < owed) begin
            cycle(1'b0, ~row.x);
            if (seen_out_valid) begin
                check_data("out_port", (made == 1) ? row.first : row.second, seen_out_port);
            end else begin
                waited++;
                if (waited > timeout_cycles) begin
                    give_up("out_valid");
                end
            end
        end
        last_out = row.has_second ? row.second : row.first;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_port    = '0;
        lfsr_state = lfsr_seed;
        owed       = 0;
        made       = 0;
        last_out   = '0;
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
        for (int i = 0; i < settle_cycles; i++) begin
            cycle(1'b0, '0);                  // nothing may come out yet
            check_count("out_valid pulses", owed, made);
        end
        for (int r = 0; r < num_rows; r++) begin
            run_row(stim_table[r]);
        end
        for (int i = 0; i < quiet_cycles; i++) begin
            cycle(1'b0, '0);
            check_count("out_valid pulses", owed, made);   // poison would show here
            check_data("out_port", last_out, seen_out_port);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== program.hex ====
// one instruction byte per line from address 0
// opcode in bits 7..4, ra in bits 3..2, rb in bits 1..0
88
04
8C
03
90
23
A0
C2
43
A0
B2
AC

// ==== project.f ====
hw/cpu_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/fetch_unit.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/cpu_top.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module cpu_tb -f project.f -o cpu_sim

run: compile
	./obj_dir/cpu_sim 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
